// ==== design/uart_pkg.sv ====
package uart_pkg;

  // --------------------------------------------------------------------------
  // Frame and divisor sizes
  // --------------------------------------------------------------------------

  // Divisor register and baud counter width
  localparam int div_width = 16;

  // Sample ticks per serial bit
  localparam int oversample = 16;

  // Data bits per frame, 8N1 only
  localparam int data_bits = 8;

  // Status word bit positions
  localparam int stat_tx_busy = 0;
  localparam int stat_rx_ready = 1;
  localparam int stat_frame_err = 2;

  // --------------------------------------------------------------------------
  // Register map and state encodings
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    ADDR_DATA   = 2'd0,
    ADDR_DIV    = 2'd1,
    ADDR_STATUS = 2'd2
  } uart_addr_e;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// ==== design/uart_ifs.sv ====
// Divisor configuration bus between the register block and the baud generator
interface br_cfg_if import uart_pkg::*; ();

  // Write strobe, only for the divisor address
  logic wr;

  // Byte lane enables, bit 1 is the upper byte
  logic [1:0] be;

  // Write data
  logic [div_width-1:0] d;

  // Current divisor for readback
  logic [div_width-1:0] rd;

  // Register side
  modport regs (
    output wr,
    output be,
    output d,
    input  rd
  );

  // Generator side
  modport gen (
    input  wr,
    input  be,
    input  d,
    output rd
  );

endinterface

// ==== design/baud_rate_gen.sv ====
module baud_rate_gen import uart_pkg::*; #(
  parameter logic [div_width-1:0] reset_divisor = 16
) (
  input  logic    br_clk,
  input  logic    rst,
  br_cfg_if.gen   cfg,
  output logic    rce,
  output logic    baud_out
);

  // Lane load enables
  logic ub_ld;
  logic lb_ld;

  // Divisor byte lanes
  logic [div_width-1:8] rate_hi;
  logic [7:0] rate_lo;
  logic [div_width-1:0] rate;

  // Reload request, one cycle after a divisor write
  logic rld;

  // Down counter
  logic c_ld;
  logic c_ce;
  logic [div_width-1:0] count;
  logic [div_width-1:0] count_next;

  // --------------------------------------------------------------------------
  // Divisor register
  // --------------------------------------------------------------------------

  assign ub_ld = cfg.wr & cfg.be[1];
  assign lb_ld = cfg.wr & cfg.be[0];

  // Each lane keeps its value unless its enable is set
  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rate_hi <= reset_divisor[div_width-1:8];
      rate_lo <= reset_divisor[7:0];
    end else begin
      if (ub_ld) begin
        rate_hi <= cfg.d[div_width-1:8];
      end
      if (lb_ld) begin
        rate_lo <= cfg.d[7:0];
      end
    end
  end

  assign rate = {rate_hi, rate_lo};
  assign cfg.rd = rate;

  // Restart the count after any lane write
  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rld <= 1'b0;
    end else begin
      rld <= ub_ld | lb_ld;
    end
  end

  // --------------------------------------------------------------------------
  // Baud counter
  // --------------------------------------------------------------------------

  // Divisor of 0 or 1 freezes the counter
  assign c_ce = (rate > div_width'(1));
  assign c_ld = (count == div_width'(1)) | rld;

  always_comb begin
    count_next = count;
    if (c_ld) begin
      count_next = rate;
    end else if (c_ce) begin
      count_next = count - div_width'(1);
    end
  end

  // Baud clock follows the next count so it is already low at the tick
  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      count    <= reset_divisor;
      baud_out <= 1'b0;
    end else begin
      count    <= count_next;
      baud_out <= c_ce & (count_next > {1'b0, rate[div_width-1:1]});
    end
  end

  // One sample tick per divisor period
  assign rce = (count == div_width'(1)) & c_ce;

endmodule

// ==== design/uart_tx.sv ====
module uart_tx import uart_pkg::*; (
  input  logic                 br_clk,
  input  logic                 rst,
  input  logic                 rce,
  input  logic                 tx_start,
  input  logic [data_bits-1:0] tx_data,
  output logic                 tx_busy,
  output logic                 tx
);

  localparam int tick_w = $clog2(oversample);
  localparam int bit_w = $clog2(data_bits);
  localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
  localparam logic [bit_w-1:0] bit_last = bit_w'(data_bits - 1);

  tx_state_e state;

  // Ticks within the current bit
  logic [tick_w-1:0] tick_cnt;

  // Data bit index
  logic [bit_w-1:0] bit_cnt;

  // Set until the first tick opens the start bit
  logic wait_tick;

  // Outgoing byte with the LSB leaving first
  logic [data_bits-1:0] shift;

  // Last tick of a bit period
  logic bit_end;

  assign bit_end = rce & (tick_cnt == tick_last);

  // --------------------------------------------------------------------------
  // Serializer FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      state     <= TX_IDLE;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      wait_tick <= 1'b0;
      tx        <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          // Line idles high
          tx <= 1'b1;
          if (tx_start) begin
            state     <= TX_START;
            tick_cnt  <= '0;
            wait_tick <= 1'b1;
          end
        end
        TX_START: begin
          if (rce && wait_tick) begin
            // Start bit begins on a tick edge
            wait_tick <= 1'b0;
            tx        <= 1'b0;
          end else if (bit_end) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= shift[0];
            state    <= TX_DATA;
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == bit_last) begin
              tx    <= 1'b1;
              state <= TX_STOP;
            end else begin
              tx      <= shift[1];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          // Busy drops at the end of the stop bit
          if (bit_end) begin
            tick_cnt <= '0;
            state    <= TX_IDLE;
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Byte capture at the start strobe and shift per data bit
  always_ff @(posedge br_clk) begin
    if (state == TX_IDLE && tx_start) begin
      shift <= tx_data;
    end else if (state == TX_DATA && bit_end) begin
      shift <= {1'b0, shift[data_bits-1:1]};
    end
  end

  assign tx_busy = (state != TX_IDLE);

endmodule

// ==== design/uart_rx.sv ====
module uart_rx import uart_pkg::*; (
  input  logic                 br_clk,
  input  logic                 rst,
  input  logic                 rce,
  input  logic                 rx,
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_ferr
);

  localparam int tick_w = $clog2(oversample);
  localparam int bit_w = $clog2(data_bits);
  localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
  localparam logic [tick_w-1:0] tick_mid = tick_w'(oversample / 2 - 1);
  localparam logic [bit_w-1:0] bit_last = bit_w'(data_bits - 1);

  rx_state_e state;

  // Two-flop synchronizer and edge history
  logic rx_meta;
  logic rx_s;
  logic rx_q;
  logic rx_fall;

  // Tick and bit counters
  logic [tick_w-1:0] tick_cnt;
  logic [bit_w-1:0] bit_cnt;

  // Incoming byte, LSB arrives first
  logic [data_bits-1:0] shift;

  // Sample point of a data or stop bit
  logic bit_end;

  // --------------------------------------------------------------------------
  // Input synchronizer
  // --------------------------------------------------------------------------

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_q    <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_q    <= rx_s;
    end
  end

  assign rx_fall = rx_q & ~rx_s;
  assign bit_end = rce & (tick_cnt == tick_last);

  // --------------------------------------------------------------------------
  // Deserializer FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_ferr  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          tick_cnt <= '0;
          if (rx_fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (rce && tick_cnt == tick_mid) begin
            // Line back high at mid-bit is a glitch
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? RX_IDLE : RX_DATA;
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == bit_last) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // Stop bit of 0 is a framing error
            rx_valid <= 1'b1;
            rx_ferr  <= ~rx_s;
            state    <= RX_IDLE;
          end else if (rce) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data shift at mid-bit
  always_ff @(posedge br_clk) begin
    if (state == RX_DATA && bit_end) begin
      shift <= {rx_s, shift[data_bits-1:1]};
    end
  end

  // Shift register holds still until the next start bit
  assign rx_data = shift;

endmodule

// ==== design/uart_regs.sv ====
module uart_regs import uart_pkg::*; (
  input  logic                 br_clk,
  input  logic                 rst,
  input  logic [1:0]           addr,
  input  logic                 wr,
  input  logic                 rd_en,
  input  logic [1:0]           be,
  input  logic [div_width-1:0] wdata,
  output logic [div_width-1:0] rdata,
  br_cfg_if.regs               cfg,
  output logic                 tx_start,
  output logic [data_bits-1:0] tx_data,
  input  logic                 tx_busy,
  input  logic [data_bits-1:0] rx_data,
  input  logic                 rx_valid,
  input  logic                 rx_ferr
);

  // Latched receive byte and its flags
  logic [data_bits-1:0] rx_byte;
  logic rx_ready;
  logic frame_err;

  // Read of the data register
  logic data_rd;

  logic [div_width-1:0] status;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  assign cfg.wr = wr & (addr == ADDR_DIV);
  assign cfg.be = be;
  assign cfg.d = wdata;

  // Transmit strobe, dropped by the serializer while busy
  assign tx_start = wr & (addr == ADDR_DATA);
  assign tx_data = wdata[data_bits-1:0];

  // --------------------------------------------------------------------------
  // Receive holding register
  // --------------------------------------------------------------------------

  assign data_rd = rd_en & (addr == ADDR_DATA);

  // New byte wins over a read in the same cycle
  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rx_ready  <= 1'b0;
      frame_err <= 1'b0;
    end else if (rx_valid) begin
      rx_ready  <= 1'b1;
      frame_err <= rx_ferr;
    end else if (data_rd) begin
      rx_ready  <= 1'b0;
      frame_err <= 1'b0;
    end
  end

  always_ff @(posedge br_clk) begin
    if (rx_valid) begin
      rx_byte <= rx_data;
    end
  end

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  always_comb begin
    status = '0;
    status[stat_tx_busy] = tx_busy;
    status[stat_rx_ready] = rx_ready;
    status[stat_frame_err] = frame_err;
  end

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd_en) begin
      case (addr)
        ADDR_DATA:   rdata <= {{(div_width - data_bits){1'b0}}, rx_byte};
        ADDR_DIV:    rdata <= cfg.rd;
        ADDR_STATUS: rdata <= status;
        default:     rdata <= '0;
      endcase
    end
  end

endmodule

// ==== design/uart_top.sv ====
module uart_top import uart_pkg::*; #(
  parameter logic [div_width-1:0] reset_divisor = 16
) (
  input  logic                 br_clk,
  input  logic                 rst,
  input  logic [1:0]           addr,
  input  logic                 wr,
  input  logic                 rd_en,
  input  logic [1:0]           be,
  input  logic [div_width-1:0] wdata,
  output logic [div_width-1:0] rdata,
  input  logic                 rx,
  output logic                 tx,
  output logic                 baud_out
);

  // Sample tick
  logic rce;

  // Transmit path
  logic tx_start;
  logic [data_bits-1:0] tx_data;
  logic tx_busy;

  // Receive path
  logic [data_bits-1:0] rx_data;
  logic rx_valid;
  logic rx_ferr;

  // Divisor configuration bus
  br_cfg_if cfg_bus ();

  // --------------------------------------------------------------------------
  // Register block and baud generator
  // --------------------------------------------------------------------------

  uart_regs u_regs (
    .br_clk   (br_clk),
    .rst      (rst),
    .addr     (addr),
    .wr       (wr),
    .rd_en    (rd_en),
    .be       (be),
    .wdata    (wdata),
    .rdata    (rdata),
    .cfg      (cfg_bus.regs),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ferr  (rx_ferr)
  );

  baud_rate_gen #(
    .reset_divisor (reset_divisor)
  ) u_gen (
    .br_clk   (br_clk),
    .rst      (rst),
    .cfg      (cfg_bus.gen),
    .rce      (rce),
    .baud_out (baud_out)
  );

  // --------------------------------------------------------------------------
  // Serial engines
  // --------------------------------------------------------------------------

  uart_tx u_tx (
    .br_clk   (br_clk),
    .rst      (rst),
    .rce      (rce),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx u_rx (
    .br_clk   (br_clk),
    .rst      (rst),
    .rce      (rce),
    .rx       (rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ferr  (rx_ferr)
  );

endmodule

// ==== verif/uart_properties.sv ====
module uart_properties (
  input logic br_clk,
  input logic rst,
  input logic tx,
  input logic tx_busy,
  input logic rce,
  input logic baud_out
);

  // --------------------------------------------------------------------------
  // Line and tick rules
  // --------------------------------------------------------------------------

  // Idle transmitter holds the line high
  property tx_high_when_idle;
    @(posedge br_clk) disable iff (rst)
      !tx_busy |-> tx;
  endproperty

  // Sample tick lasts one cycle
  property rce_single_cycle;
    @(posedge br_clk) disable iff (rst)
      rce |=> !rce;
  endproperty

  // Baud clock already low in the tick cycle
  property baud_low_at_tick;
    @(posedge br_clk) disable iff (rst)
      rce |-> !baud_out;
  endproperty

  a_tx_high_when_idle: assert property (tx_high_when_idle)
    else $error("tx is low while the transmitter is idle");

  a_rce_single_cycle: assert property (rce_single_cycle)
    else $error("rce is high for two cycles in a row");

  a_baud_low_at_tick: assert property (baud_low_at_tick)
    else $error("baud_out is high during a sample tick");

endmodule

// Bound to the top level where tx_busy and rce are internal nets
bind uart_top uart_properties props (
  .br_clk   (br_clk),
  .rst      (rst),
  .tx       (tx),
  .tx_busy  (tx_busy),
  .rce      (rce),
  .baud_out (baud_out)
);

// ==== verif/uart_tb.sv ====
module uart_tb import uart_pkg::*; ();

  localparam logic [div_width-1:0] reset_div = 16'd16;
  localparam int start_limit = 2000;
  localparam int frame_limit = 20000;
  localparam int edge_limit = 64;
  localparam int poll_limit = 4000;
  localparam int frame_div = 4;

  logic br_clk;
  logic rst;
  logic [1:0] addr;
  logic wr;
  logic rd_en;
  logic [1:0] be;
  logic [div_width-1:0] wdata;
  logic [div_width-1:0] rdata;
  logic rx;
  logic tx;
  logic baud_out;

  // Loopback mux, tb_line replaces tx when line_sel is set
  logic line_sel;
  logic tb_line;

  int seed;
  int check_errs;
  int timeout_errs;

  // Hand-off to the compare process
  logic cmp_armed;
  logic cmp_done;
  logic [9:0] cmp_frame;
  int cmp_div;

  logic [div_width-1:0] div_model;
  logic [div_width-1:0] rd_val;
  logic [div_width-1:0] new_div;
  logic [7:0] tx_byte;
  int period;

  assign rx = line_sel ? tb_line : tx;

  uart_top #(
    .reset_divisor (reset_div)
  ) dut (
    .br_clk   (br_clk),
    .rst      (rst),
    .addr     (addr),
    .wr       (wr),
    .rd_en    (rd_en),
    .be       (be),
    .wdata    (wdata),
    .rdata    (rdata),
    .rx       (rx),
    .tx       (tx),
    .baud_out (baud_out)
  );

  initial begin
    br_clk = 1'b0;
    forever #2 br_clk = ~br_clk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // 8N1 frame in line order, bit 0 is the start bit
  function automatic logic [9:0] frame_for(input logic [7:0] b);
    logic [9:0] f;
    f[0] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      f[i+1] = b[i];
    end
    f[9] = 1'b1;
    return f;
  endfunction

  // Only enabled lanes take the new byte
  function automatic logic [15:0] divisor_after(input logic [15:0] old,
                                                input logic [1:0] lanes,
                                                input logic [15:0] d);
    logic [15:0] r;
    r = old;
    if (lanes[0]) begin
      r[7:0] = d[7:0];
    end
    if (lanes[1]) begin
      r[15:8] = d[15:8];
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Bus and line tasks
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    check_errs++;
    $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic report_timeout(input string what);
    timeout_errs++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic write_reg(input uart_addr_e a, input logic [1:0] lanes,
                           input logic [15:0] d);
    @(posedge br_clk);
    addr  <= a;
    be    <= lanes;
    wdata <= d;
    wr    <= 1'b1;
    @(posedge br_clk);
    wr <= 1'b0;
  endtask

  // Returns at a falling edge with rdata captured
  task automatic read_reg(input uart_addr_e a, output logic [15:0] d);
    @(posedge br_clk);
    addr  <= a;
    rd_en <= 1'b1;
    @(posedge br_clk);
    rd_en <= 1'b0;
    @(negedge br_clk);
    d = rdata;
  endtask

  task automatic wait_status_bit(input int bit_idx, input logic level, input string what);
    logic [15:0] s;
    int n;
    n = 0;
    read_reg(ADDR_STATUS, s);
    while (s[bit_idx] !== level && n < poll_limit) begin
      read_reg(ADDR_STATUS, s);
      n++;
    end
    if (s[bit_idx] !== level) begin
      report_timeout(what);
    end
  endtask

  task automatic lane_write(input logic [1:0] lanes, input logic [15:0] d);
    write_reg(ADDR_DIV, lanes, d);
    div_model = divisor_after(div_model, lanes, d);
    read_reg(ADDR_DIV, rd_val);
    if (rd_val !== div_model) begin
      report_mismatch("divisor", rd_val, div_model);
    end
  endtask

  // Call at a falling edge, n counts cycles up to the rise
  task automatic wait_baud_rise(output int n);
    logic last;
    logic rose;
    last = baud_out;
    rose = 1'b0;
    n = 0;
    while (!rose && n < edge_limit) begin
      @(negedge br_clk);
      rose = baud_out && !last;
      last = baud_out;
      n++;
    end
    if (!rose) begin
      report_timeout("a rising edge on baud_out");
    end
  endtask

  task automatic send_and_check(input logic [7:0] b, input int div);
    int n;
    cmp_frame = frame_for(b);
    cmp_div   = div;
    cmp_done  = 1'b0;
    cmp_armed = 1'b1;
    write_reg(ADDR_DATA, 2'b11, {8'd0, b});
    n = 0;
    while (!cmp_done && n < frame_limit) begin
      @(negedge br_clk);
      n++;
    end
    if (!cmp_done) begin
      report_timeout("the tx frame compare");
    end
  endtask

  // Frame on the receiver input with a chosen stop bit
  task automatic drive_rx_frame(input logic [7:0] b, input logic stop_bit, input int div);
    logic [9:0] f;
    f = frame_for(b);
    f[9] = stop_bit;
    @(posedge br_clk);
    line_sel <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      tb_line <= f[i];
      repeat (16 * div) @(posedge br_clk);
    end
    tb_line <= 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Compare process for tx
  // --------------------------------------------------------------------------

  // Bit centers sit 8 and then every 16 divisor periods past the start edge
  task automatic check_tx_frame(input logic [9:0] f, input int div);
    int n;
    n = 0;
    while (tx !== 1'b0 && n < start_limit) begin
      @(negedge br_clk);
      n++;
    end
    if (tx !== 1'b0) begin
      report_timeout("the start bit on tx");
    end else begin
      repeat (8 * div) @(negedge br_clk);
      for (int i = 0; i < 10; i++) begin
        if (tx !== f[i]) begin
          report_mismatch($sformatf("tx bit %0d", i), {15'd0, tx}, {15'd0, f[i]});
        end
        if (i < 9) begin
          repeat (16 * div) @(negedge br_clk);
        end
      end
    end
  endtask

  initial begin : tx_compare
    forever begin
      @(negedge br_clk);
      if (cmp_armed) begin
        check_tx_frame(cmp_frame, cmp_div);
        cmp_armed = 1'b0;
        cmp_done  = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    seed = 5;
    check_errs = 0;
    timeout_errs = 0;
    cmp_armed = 1'b0;
    cmp_done = 1'b0;
    cmp_frame = '0;
    cmp_div = 0;
    rst = 1'b1;
    addr = 2'd0;
    wr = 1'b0;
    rd_en = 1'b0;
    be = 2'b00;
    wdata = '0;
    line_sel = 1'b0;
    tb_line = 1'b1;
    repeat (16) @(posedge br_clk);
    rst <= 1'b0;

    // State after reset
    @(negedge br_clk);
    if (tx !== 1'b1) begin
      report_mismatch("tx", {15'd0, tx}, 16'd1);
    end
    read_reg(ADDR_STATUS, rd_val);
    if (rd_val !== 16'h0000) begin
      report_mismatch("status", rd_val, 16'h0000);
    end
    read_reg(ADDR_DIV, rd_val);
    if (rd_val !== reset_div) begin
      report_mismatch("divisor", rd_val, reset_div);
    end
    div_model = reset_div;

    // Byte lanes, every result stays above 1
    lane_write(2'b01, 16'h12ab);
    lane_write(2'b10, 16'h0300);
    lane_write(2'b00, 16'hffff);
    lane_write(2'b11, 16'(2 + {$random(seed)} % 1000));

    // Baud clock period
    for (int k = 0; k < 6; k++) begin
      new_div = 16'(2 + {$random(seed)} % 19);
      write_reg(ADDR_DIV, 2'b11, new_div);
      repeat (4) @(posedge br_clk);
      @(negedge br_clk);
      wait_baud_rise(period);
      wait_baud_rise(period);
      if (period != int'(new_div)) begin
        report_mismatch("baud_out period", 16'(period), new_div);
      end
    end

    // Transmit frames, looped back into the receiver
    write_reg(ADDR_DIV, 2'b11, 16'(frame_div));
    for (int k = 0; k < 3; k++) begin
      tx_byte = 8'($random(seed));
      send_and_check(tx_byte, frame_div);
      wait_status_bit(stat_rx_ready, 1'b1, "rx_ready to set");
      read_reg(ADDR_STATUS, rd_val);
      if (rd_val[stat_frame_err] !== 1'b0) begin
        report_mismatch("frame_err", {15'd0, rd_val[stat_frame_err]}, 16'd0);
      end
      read_reg(ADDR_DATA, rd_val);
      if (rd_val !== {8'd0, tx_byte}) begin
        report_mismatch("rx data", rd_val, {8'd0, tx_byte});
      end
      read_reg(ADDR_STATUS, rd_val);
      if (rd_val[stat_rx_ready] !== 1'b0) begin
        report_mismatch("rx_ready", {15'd0, rd_val[stat_rx_ready]}, 16'd0);
      end
      wait_status_bit(stat_tx_busy, 1'b0, "tx_busy to fall");
    end

    // Stop bit of 0 from the testbench line
    drive_rx_frame(8'h3c, 1'b0, frame_div);
    wait_status_bit(stat_frame_err, 1'b1, "frame_err to set");
    read_reg(ADDR_DATA, rd_val);
    if (rd_val !== 16'h003c) begin
      report_mismatch("rx data", rd_val, 16'h003c);
    end
    read_reg(ADDR_STATUS, rd_val);
    if (rd_val !== 16'h0000) begin
      report_mismatch("status", rd_val, 16'h0000);
    end

    $display("check errors: %0d, timeouts: %0d", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/uart_pkg.sv
design/uart_ifs.sv
design/baud_rate_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_top.sv
verif/uart_properties.sv
verif/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= uart_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TB FAILED
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
